/* dlx_exec_pipe.f */
hdl/dlx_pkg.sv
hdl/dec_ex_if.sv
hdl/ex_wb_if.sv
hdl/issue_stage.sv
hdl/register_file.sv
hdl/alu.sv
hdl/decode_stage.sv
hdl/execute.sv
hdl/writeback_stage.sv
hdl/dlx_exec_pipe.sv
sim/dlx_exec_pipe_tb.sv

/* hdl/alu.sv */
`timescale 1ns/1ps

module alu (
    input  logic [0:31] a,
    input  logic [0:31] b,
    input  logic [0:3]  ctrl,
    input  logic        mul,
    output logic [0:31] result,
    output logic        zero
);
    import dlx_pkg::*;

    logic [0:4]  shamt;
    logic [0:31] product;
    logic [0:31] logic_res;

    assign shamt   = b[27:31];                   // low five bits of b.
    assign product = $signed(a) * $signed(b);    // only the low word is kept.

    always_comb begin
        case (ctrl)
            ALU_ADD: logic_res = a + b;
            ALU_SUB: logic_res = a - b;
            ALU_AND: logic_res = a & b;
            ALU_OR:  logic_res = a | b;
            ALU_XOR: logic_res = a ^ b;
            ALU_SLL: logic_res = a << shamt;
            ALU_SRL: logic_res = a >> shamt;
            ALU_SLT: logic_res = {31'd0, $signed(a) < $signed(b)};
            default: logic_res = '0;
        endcase
    end

    assign result = mul ? product : logic_res;

    // branches test register A, not the result.
    assign zero = (a == 32'd0);

endmodule

/* hdl/dec_ex_if.sv */
`timescale 1ns/1ps

interface dec_ex_if;
    logic        valid;
    logic [0:31] next_pc;
    logic [0:31] op_a;
    logic [0:31] op_b;
    logic [0:31] imm16;    // already sign-extended.
    logic [0:31] offset26; // already sign-extended.
    logic [0:4]  dest;
    logic [0:3]  alu_ctrl;
    logic        mul;
    logic        reg_write;
    logic        branch;
    logic        branch_zero;
    logic        jump;
    logic        reg_to_pc;
    logic        pc_to_reg;

    modport src (output valid, next_pc, op_a, op_b, imm16, offset26, dest, alu_ctrl,
                 mul, reg_write, branch, branch_zero, jump, reg_to_pc, pc_to_reg);

    modport dst (input valid, next_pc, op_a, op_b, imm16, offset26, dest, alu_ctrl,
                 mul, reg_write, branch, branch_zero, jump, reg_to_pc, pc_to_reg);

endinterface

/* hdl/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            iss_valid,
    input  dlx_pkg::instr_u iss_instr,
    input  logic [0:31]     iss_pc,
    input  logic            ex_valid,
    input  logic            ex_reg_write,
    input  logic [0:4]      ex_dest,
    input  logic [0:31]     ex_result,
    input  logic            we,
    input  logic [0:4]      waddr,
    input  logic [0:31]     wdata,
    dec_ex_if.src           dx
);
    import dlx_pkg::*;

    logic [0:5]  opcode;
    logic [0:31] rdata_a;
    logic [0:31] rdata_b;
    logic [0:31] imm_ext;
    logic [0:31] off_ext;
    logic [0:4]  dest;
    logic [0:3]  alu_ctrl;
    logic        mul;
    logic        reg_write;
    logic        use_imm;
    logic        branch;
    logic        branch_zero;
    logic        jump;
    logic        reg_to_pc;
    logic        pc_to_reg;

    // the execute register wins over the write port and the write port over the array.
    function automatic logic [0:31] bypass(input logic [0:4] addr, input logic [0:31] rf_data);
        if (ex_valid && ex_reg_write && ex_dest == addr && addr != 5'd0)
            return ex_result;
        if (we && waddr == addr)
            return wdata;
        return rf_data;
    endfunction

    register_file i_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .raddr_a (iss_instr.r_fmt.rs1), // rs1 sits at the same bits in every view.
        .raddr_b (iss_instr.r_fmt.rs2),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b),
        .we      (we),
        .waddr   (waddr),
        .wdata   (wdata)
    );

    assign opcode  = iss_instr.r_fmt.opcode;
    assign imm_ext = {{16{iss_instr.i_fmt.imm16[0]}}, iss_instr.i_fmt.imm16};
    assign off_ext = {{6{iss_instr.j_fmt.offset26[0]}}, iss_instr.j_fmt.offset26};

    always_comb begin
        dest        = iss_instr.i_fmt.rd;
        alu_ctrl    = ALU_ADD;
        mul         = 1'b0;
        reg_write   = 1'b0;
        use_imm     = 1'b1;
        branch      = 1'b0;
        branch_zero = 1'b0;
        jump        = 1'b0;
        reg_to_pc   = 1'b0;
        pc_to_reg   = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                dest      = iss_instr.r_fmt.rd;
                use_imm   = 1'b0;
                reg_write = 1'b1;
                case (iss_instr.r_fmt.func)
                    FN_ADD:  alu_ctrl = ALU_ADD;
                    FN_SUB:  alu_ctrl = ALU_SUB;
                    FN_AND:  alu_ctrl = ALU_AND;
                    FN_OR:   alu_ctrl = ALU_OR;
                    FN_XOR:  alu_ctrl = ALU_XOR;
                    FN_SLL:  alu_ctrl = ALU_SLL;
                    FN_SRL:  alu_ctrl = ALU_SRL;
                    FN_SLT:  alu_ctrl = ALU_SLT;
                    FN_MUL:  mul = 1'b1;
                    default: reg_write = 1'b0; // unknown function retires as a no-op.
                endcase
            end
            OP_ADDI: reg_write = 1'b1;
            OP_ANDI: begin
                alu_ctrl  = ALU_AND;
                reg_write = 1'b1;
            end
            OP_ORI: begin
                alu_ctrl  = ALU_OR;
                reg_write = 1'b1;
            end
            OP_XORI: begin
                alu_ctrl  = ALU_XOR;
                reg_write = 1'b1;
            end
            OP_BEQZ: begin
                branch      = 1'b1;
                branch_zero = 1'b1;
            end
            OP_BNEZ: branch = 1'b1;
            OP_J:    jump = 1'b1;
            OP_JR: begin
                jump      = 1'b1;
                reg_to_pc = 1'b1;
            end
            OP_JAL, OP_JALR: begin
                dest      = LINK_REG;
                jump      = 1'b1;
                reg_to_pc = (opcode == OP_JALR);
                pc_to_reg = 1'b1;
                reg_write = 1'b1;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dx.valid       <= 1'b0;
            dx.mul         <= 1'b0;
            dx.reg_write   <= 1'b0;
            dx.branch      <= 1'b0;
            dx.branch_zero <= 1'b0;
            dx.jump        <= 1'b0;
            dx.reg_to_pc   <= 1'b0;
            dx.pc_to_reg   <= 1'b0;
        end else begin
            dx.valid       <= iss_valid;
            dx.mul         <= mul;
            dx.reg_write   <= reg_write;
            dx.branch      <= branch;
            dx.branch_zero <= branch_zero;
            dx.jump        <= jump;
            dx.reg_to_pc   <= reg_to_pc;
            dx.pc_to_reg   <= pc_to_reg;
        end
    end

    always_ff @(posedge clk) begin
        dx.next_pc  <= iss_pc;
        dx.op_a     <= bypass(iss_instr.r_fmt.rs1, rdata_a);
        dx.op_b     <= use_imm ? imm_ext : bypass(iss_instr.r_fmt.rs2, rdata_b);
        dx.imm16    <= imm_ext;
        dx.offset26 <= off_ext;
        dx.dest     <= dest;
        dx.alu_ctrl <= alu_ctrl;
    end

    a_decoded_known: assert property (@(posedge clk) disable iff (!arst_n)
        dx.valid |-> !$isunknown({dx.alu_ctrl, dx.dest, dx.op_a, dx.op_b, dx.next_pc}));

endmodule

/* hdl/dlx_exec_pipe.sv */
`timescale 1ns/1ps

module dlx_exec_pipe (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req,
    output logic        ack,
    input  logic [0:31] instr,
    input  logic [0:31] next_pc,
    output logic        wb_valid,
    output logic        wb_write,
    output logic [0:4]  wb_dest,
    output logic [0:31] wb_data,
    output logic        leap,
    output logic [0:31] leap_addr
);
    import dlx_pkg::*;

    logic        iss_valid;
    instr_u      iss_instr;
    logic [0:31] iss_pc;
    logic        we;
    logic [0:4]  waddr;
    logic [0:31] wdata;

    dec_ex_if dx_bus ();
    ex_wb_if  xw_bus ();

    issue_stage i_issue_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .ack       (ack),
        .instr     (instr),
        .next_pc   (next_pc),
        .iss_valid (iss_valid),
        .iss_instr (iss_instr),
        .iss_pc    (iss_pc)
    );

    decode_stage i_decode_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .iss_valid    (iss_valid),
        .iss_instr    (iss_instr),
        .iss_pc       (iss_pc),
        .ex_valid     (xw_bus.valid),     // bypass from the execute register.
        .ex_reg_write (xw_bus.reg_write),
        .ex_dest      (xw_bus.dest),
        .ex_result    (xw_bus.result),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata),
        .dx           (dx_bus.src)
    );

    execute i_execute (
        .clk    (clk),
        .arst_n (arst_n),
        .dx     (dx_bus.dst),
        .xw     (xw_bus.src)
    );

    writeback_stage i_writeback_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .xw        (xw_bus.dst),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .wb_valid  (wb_valid),
        .wb_write  (wb_write),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .leap      (leap),
        .leap_addr (leap_addr)
    );

endmodule

/* hdl/dlx_pkg.sv */
package dlx_pkg;

    // opcodes sit in bits 0 to 5 of the instruction word.
    localparam logic [0:5] OP_RTYPE = 6'h00;
    localparam logic [0:5] OP_J     = 6'h02;
    localparam logic [0:5] OP_JAL   = 6'h03;
    localparam logic [0:5] OP_BEQZ  = 6'h04;
    localparam logic [0:5] OP_BNEZ  = 6'h05;
    localparam logic [0:5] OP_ADDI  = 6'h08;
    localparam logic [0:5] OP_ANDI  = 6'h0C;
    localparam logic [0:5] OP_ORI   = 6'h0D;
    localparam logic [0:5] OP_XORI  = 6'h0E;
    localparam logic [0:5] OP_JR    = 6'h12;
    localparam logic [0:5] OP_JALR  = 6'h13;

    // function field of the R-type word.
    localparam logic [0:10] FN_SLL = 11'h004;
    localparam logic [0:10] FN_SRL = 11'h006;
    localparam logic [0:10] FN_MUL = 11'h00E;
    localparam logic [0:10] FN_ADD = 11'h020;
    localparam logic [0:10] FN_SUB = 11'h022;
    localparam logic [0:10] FN_AND = 11'h024;
    localparam logic [0:10] FN_OR  = 11'h025;
    localparam logic [0:10] FN_XOR = 11'h026;
    localparam logic [0:10] FN_SLT = 11'h02A;

    localparam logic [0:3] ALU_ADD = 4'd0;
    localparam logic [0:3] ALU_SUB = 4'd1;
    localparam logic [0:3] ALU_AND = 4'd2;
    localparam logic [0:3] ALU_OR  = 4'd3;
    localparam logic [0:3] ALU_XOR = 4'd4;
    localparam logic [0:3] ALU_SLL = 4'd5;
    localparam logic [0:3] ALU_SRL = 4'd6;
    localparam logic [0:3] ALU_SLT = 4'd7;

    localparam logic [0:4] LINK_REG = 5'd31; // jal and jalr write here.

    typedef union packed {
        struct packed {
            logic [0:5]  opcode;
            logic [0:4]  rs1;
            logic [0:4]  rs2;
            logic [0:4]  rd;
            logic [0:10] func;
        } r_fmt;
        struct packed {
            logic [0:5]  opcode;
            logic [0:4]  rs1;
            logic [0:4]  rd;
            logic [0:15] imm16;
        } i_fmt;
        struct packed {
            logic [0:5]  opcode;
            logic [0:25] offset26;
        } j_fmt;
    } instr_u;

endpackage

/* hdl/ex_wb_if.sv */
`timescale 1ns/1ps

interface ex_wb_if;
    logic        valid;
    logic        reg_write; // already qualified by valid.
    logic [0:4]  dest;
    logic [0:31] result;
    logic        leap;
    logic [0:31] leap_addr;

    modport src (
        output valid, reg_write, dest, result, leap, leap_addr
    );

    modport dst (
        input valid, reg_write, dest, result, leap, leap_addr
    );

endinterface

/* hdl/execute.sv */
`timescale 1ns/1ps

module execute (
    input  logic  clk,
    input  logic  arst_n,
    dec_ex_if.dst dx,
    ex_wb_if.src  xw
);

    logic [0:31] alu_result;
    logic        alu_zero;
    logic        leap;
    logic [0:31] offset;
    logic [0:31] target;
    logic [0:31] leap_addr;
    logic [0:31] result;

    alu i_alu (
        .a      (dx.op_a),
        .b      (dx.op_b),
        .ctrl   (dx.alu_ctrl),
        .mul    (dx.mul),
        .result (alu_result),
        .zero   (alu_zero)
    );

    // beqz leaps on zero, bnez on non-zero.
    assign leap = dx.jump | (dx.branch & (alu_zero ~^ dx.branch_zero));

    assign offset    = dx.branch ? dx.imm16 : dx.offset26;
    assign target    = dx.next_pc + offset;
    assign leap_addr = dx.reg_to_pc ? dx.op_a : target; // jr and jalr take register A.

    assign result = dx.pc_to_reg ? dx.next_pc : alu_result; // link value for jal and jalr.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            xw.valid     <= 1'b0;
            xw.reg_write <= 1'b0;
            xw.leap      <= 1'b0;
        end else begin
            xw.valid     <= dx.valid;
            xw.reg_write <= dx.valid & dx.reg_write;
            xw.leap      <= dx.valid & leap;
        end
    end

    always_ff @(posedge clk) begin
        xw.dest      <= dx.dest;
        xw.result    <= result;
        xw.leap_addr <= leap_addr;
    end

endmodule

/* hdl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            req,
    output logic            ack,
    input  logic [0:31]     instr,
    input  logic [0:31]     next_pc,
    output logic            iss_valid,
    output dlx_pkg::instr_u iss_instr,
    output logic [0:31]     iss_pc
);

    logic accept;

    assign accept = req & ~ack; // a new word is waiting.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack       <= 1'b0;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= accept;
            if (accept) begin
                ack <= 1'b1;
            end else if (!req && ack) begin
                ack <= 1'b0; // return to idle once the sender lets go.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_instr <= instr;
            iss_pc    <= next_pc;
        end
    end

    // the sender may only withdraw req after it has seen ack.
    a_req_held: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(req) |-> ack);

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps

module register_file (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [0:4]  raddr_a,
    input  logic [0:4]  raddr_b,
    output logic [0:31] rdata_a,
    output logic [0:31] rdata_b,
    input  logic        we,
    input  logic [0:4]  waddr,
    input  logic [0:31] wdata
);

    logic [0:31] regs [0:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata; // r0 stays zero.
        end
    end

    // no write-through here.
    // The decode stage covers same-cycle writes.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

/* hdl/writeback_stage.sv */
`timescale 1ns/1ps

module writeback_stage (
    input  logic        clk,
    input  logic        arst_n,
    ex_wb_if.dst        xw,
    output logic        we,
    output logic [0:4]  waddr,
    output logic [0:31] wdata,
    output logic        wb_valid,
    output logic        wb_write,
    output logic [0:4]  wb_dest,
    output logic [0:31] wb_data,
    output logic        leap,
    output logic [0:31] leap_addr
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
            wb_write <= 1'b0;
            leap     <= 1'b0;
        end else begin
            wb_valid <= xw.valid;
            wb_write <= xw.reg_write & (xw.dest != 5'd0); // r0 is never written.
            leap     <= xw.valid & xw.leap;
        end
    end

    always_ff @(posedge clk) begin
        wb_dest   <= xw.dest;
        wb_data   <= xw.result;
        leap_addr <= xw.leap_addr;
    end

    // the register file takes its write from the report registers.
    assign we    = wb_write;
    assign waddr = wb_dest;
    assign wdata = wb_data;

    a_write_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
        wb_write |-> wb_valid);

endmodule

/* sim/dlx_exec_pipe_tb.sv */
`timescale 1ns/1ps

module dlx_exec_pipe_tb;
    import dlx_pkg::*;

    localparam int TIMEOUT = 20;

    logic        clk;
    logic        arst_n;
    logic        req;
    logic        ack;
    logic [31:0] instr;
    logic [31:0] next_pc;
    logic        wb_valid;
    logic        wb_write;
    logic [4:0]  wb_dest;
    logic [31:0] wb_data;
    logic        leap;
    logic [31:0] leap_addr;

    logic [31:0] ref_regs [32]; // architectural registers as the model sees them.
    logic [31:0] pc;
    int          mismatches;
    int          failures;
    string       test_name;

    // expected retire reports with the oldest first.
    string       exp_name  [$];
    bit          exp_write [$];
    logic [4:0]  exp_dest  [$];
    logic [31:0] exp_data  [$];
    bit          exp_leap  [$];
    logic [31:0] exp_laddr [$];

    dlx_exec_pipe i_dlx_exec_pipe (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .ack       (ack),
        .instr     (instr),
        .next_pc   (next_pc),
        .wb_valid  (wb_valid),
        .wb_write  (wb_write),
        .wb_dest   (wb_dest),
        .wb_data   (wb_data),
        .leap      (leap),
        .leap_addr (leap_addr)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] r_word(input logic [10:0] fn, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2);
        return {OP_RTYPE, rs1, rs2, rd, fn};
    endfunction

    function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [15:0] imm);
        return {op, rs1, rd, imm};
    endfunction

    function automatic logic [31:0] j_word(input logic [5:0] op, input logic [25:0] off);
        return {op, off};
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        failures++;
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_value(input string name, input string field,
                               input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            $display("mismatch %s %s: expected %h, actual %h", name, field, exp, act);
            mismatches++;
        end
    endtask

    // the reference model decodes the word by the field rules and retires it in order.
    task automatic predict(input logic [31:0] word, input logic [31:0] npc);
        logic [5:0]  op;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  dest;
        logic [10:0] fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] soff;
        logic [31:0] data;
        logic [31:0] laddr;
        bit          wr;
        bit          lp;
        op    = word[31:26];
        rs1   = word[25:21];
        rs2   = word[20:16];
        fn    = word[10:0];
        a     = ref_regs[rs1];
        b     = ref_regs[rs2];
        simm  = {{16{word[15]}}, word[15:0]};
        soff  = {{6{word[25]}}, word[25:0]};
        dest  = rs2; // the I-type rd field.
        data  = '0;
        laddr = '0;
        wr    = 1'b0;
        lp    = 1'b0;
        case (op)
            OP_RTYPE: begin
                dest = word[15:11];
                wr   = 1'b1;
                case (fn)
                    FN_ADD:  data = a + b;
                    FN_SUB:  data = a - b;
                    FN_AND:  data = a & b;
                    FN_OR:   data = a | b;
                    FN_XOR:  data = a ^ b;
                    FN_SLL:  data = a << b[4:0];
                    FN_SRL:  data = a >> b[4:0];
                    FN_SLT:  data = {31'd0, $signed(a) < $signed(b)};
                    FN_MUL:  data = a * b; // the low word is the same signed or not.
                    default: wr = 1'b0;
                endcase
            end
            OP_ADDI: begin
                wr   = 1'b1;
                data = a + simm;
            end
            OP_ANDI: begin
                wr   = 1'b1;
                data = a & simm;
            end
            OP_ORI: begin
                wr   = 1'b1;
                data = a | simm;
            end
            OP_XORI: begin
                wr   = 1'b1;
                data = a ^ simm;
            end
            OP_BEQZ: begin
                lp    = (a == 0);
                laddr = npc + simm;
            end
            OP_BNEZ: begin
                lp    = (a != 0);
                laddr = npc + simm;
            end
            OP_J: begin
                lp    = 1'b1;
                laddr = npc + soff;
            end
            OP_JR: begin
                lp    = 1'b1;
                laddr = a;
            end
            OP_JAL: begin
                lp    = 1'b1;
                laddr = npc + soff;
                dest  = 5'd31;
                wr    = 1'b1;
                data  = npc;
            end
            OP_JALR: begin
                lp    = 1'b1;
                laddr = a;
                dest  = 5'd31;
                wr    = 1'b1;
                data  = npc;
            end
            default: ;
        endcase
        wr = wr && dest != 5'd0;
        if (wr)
            ref_regs[dest] = data;
        exp_name.push_back(test_name);
        exp_write.push_back(wr);
        exp_dest.push_back(dest);
        exp_data.push_back(data);
        exp_leap.push_back(lp);
        exp_laddr.push_back(laddr);
    endtask

    // runs one four-phase transfer that starts and ends on a falling edge.
    task automatic issue_word(input logic [31:0] word, input logic [31:0] npc, input int gap);
        int n;
        repeat (gap) @(negedge clk);
        instr   = word;
        next_pc = npc;
        req     = 1'b1;
        n = 0;
        while (ack !== 1'b1 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== 1'b1)
            abort_run("timeout waiting for ack to rise");
        req = 1'b0;
        n = 0;
        while (ack !== 1'b0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack !== 1'b0)
            abort_run("timeout waiting for ack to fall");
    endtask

    task automatic run_instr(input logic [31:0] word, input int gap);
        predict(word, pc + 32'd4);
        issue_word(word, pc + 32'd4, gap);
        pc = pc + 32'd4;
    endtask

    task automatic drain_reports();
        int n;
        n = 0;
        while (exp_name.size() != 0 && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (exp_name.size() != 0)
            abort_run("timeout waiting for a retire report");
    endtask

    task automatic check_report();
        string       name;
        bit          wr;
        bit          lp;
        logic [4:0]  dest;
        logic [31:0] data;
        logic [31:0] laddr;
        assert (exp_name.size() != 0) else begin
            $display("retire report seen with no instruction outstanding");
            failures++;
        end
        if (exp_name.size() != 0) begin
            name  = exp_name.pop_front();
            wr    = exp_write.pop_front();
            dest  = exp_dest.pop_front();
            data  = exp_data.pop_front();
            lp    = exp_leap.pop_front();
            laddr = exp_laddr.pop_front();
            check_value(name, "wb_write", wr, wb_write);
            check_value(name, "leap", lp, leap);
            if (wr) begin
                check_value(name, "wb_dest", dest, wb_dest);
                check_value(name, "wb_data", data, wb_data);
            end
            if (lp)
                check_value(name, "leap_addr", laddr, leap_addr);
        end
    endtask

    always @(negedge clk) begin
        if (arst_n === 1'b1 && wb_valid === 1'b1)
            check_report();
    end

    task automatic rtype_ops();
        test_name = "rtype";
        assert (ack === 1'b0 && wb_valid === 1'b0) else begin
            $display("ack or wb_valid not low after reset");
            failures++;
        end
        run_instr(i_word(OP_ADDI, 5'd1, 5'd0, 16'd100), 0);
        run_instr(i_word(OP_ADDI, 5'd2, 5'd0, 16'hFFF9), 0); // -7.
        run_instr(i_word(OP_ADDI, 5'd3, 5'd0, 16'd5), 0);
        run_instr(i_word(OP_ADDI, 5'd4, 5'd0, 16'h7ABC), 0);
        run_instr(r_word(FN_ADD, 5'd5, 5'd1, 5'd2), 0);
        run_instr(r_word(FN_SUB, 5'd5, 5'd2, 5'd1), 0);
        run_instr(r_word(FN_AND, 5'd5, 5'd4, 5'd2), 0);
        run_instr(r_word(FN_OR, 5'd5, 5'd4, 5'd1), 0);
        run_instr(r_word(FN_XOR, 5'd5, 5'd4, 5'd2), 0);
        run_instr(r_word(FN_SLL, 5'd6, 5'd2, 5'd3), 0);
        run_instr(r_word(FN_SRL, 5'd6, 5'd2, 5'd3), 0);
        run_instr(r_word(FN_SLT, 5'd7, 5'd2, 5'd1), 1);
        run_instr(r_word(FN_SLT, 5'd7, 5'd1, 5'd2), 0);
        run_instr(r_word(FN_MUL, 5'd8, 5'd1, 5'd2), 0);
        run_instr(r_word(FN_MUL, 5'd8, 5'd4, 5'd4), 0);
        drain_reports();
    endtask

    task automatic imm_ops();
        test_name = "immediate";
        run_instr(i_word(OP_ADDI, 5'd9, 5'd1, 16'hFED4), 0); // -300.
        run_instr(i_word(OP_ANDI, 5'd9, 5'd2, 16'h8F0F), 0);
        run_instr(i_word(OP_ORI, 5'd9, 5'd1, 16'hFFF0), 0);
        run_instr(i_word(OP_XORI, 5'd9, 5'd2, 16'h7FFF), 0);
        run_instr(i_word(OP_ADDI, 5'd0, 5'd1, 16'd55), 0);
        run_instr(r_word(FN_ADD, 5'd10, 5'd0, 5'd1), 1);
        drain_reports();
    endtask

    // gap 0 hits the execute bypass, gap 1 the write-port bypass.
    task automatic dep_chain();
        test_name = "chain";
        run_instr(i_word(OP_ADDI, 5'd11, 5'd0, 16'd3), 0);
        run_instr(r_word(FN_ADD, 5'd12, 5'd11, 5'd11), 0);
        run_instr(r_word(FN_SUB, 5'd13, 5'd12, 5'd11), 1);
        run_instr(r_word(FN_MUL, 5'd14, 5'd13, 5'd12), 0);
        run_instr(r_word(FN_XOR, 5'd15, 5'd14, 5'd13), 1);
        run_instr(r_word(FN_SLT, 5'd16, 5'd13, 5'd15), 0);
        run_instr(i_word(OP_ADDI, 5'd11, 5'd16, 16'hFFFF), 1);
        drain_reports();
    endtask

    task automatic branches();
        test_name = "branch";
        run_instr(i_word(OP_BEQZ, 5'd0, 5'd0, 16'd8), 0);
        run_instr(i_word(OP_BEQZ, 5'd0, 5'd1, 16'hFFF4), 0);
        run_instr(i_word(OP_BNEZ, 5'd0, 5'd1, 16'hFF00), 0);
        run_instr(i_word(OP_BNEZ, 5'd0, 5'd17, 16'h0010), 0);
        run_instr(i_word(OP_BEQZ, 5'd0, 5'd17, 16'h8000), 0);
        drain_reports();
    endtask

    task automatic jumps();
        test_name = "jump";
        run_instr(j_word(OP_J, 26'h0000040), 0);
        run_instr(j_word(OP_J, 26'h3E00000), 0);
        run_instr(j_word(OP_JAL, 26'h0001234), 0);
        run_instr(r_word(FN_ADD, 5'd18, 5'd31, 5'd0), 0); // reads the link value.
        run_instr(i_word(OP_JR, 5'd0, 5'd1, 16'd0), 0);
        run_instr(i_word(OP_JALR, 5'd0, 5'd2, 16'd0), 0);
        run_instr(r_word(FN_ADD, 5'd19, 5'd31, 5'd3), 1);
        drain_reports();
    endtask

    function automatic logic [31:0] random_word();
        logic [10:0] fns [9];
        logic [5:0]  iops [4];
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [15:0] imm;
        int          k;
        fns  = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLL, FN_SRL, FN_SLT, FN_MUL};
        iops = '{OP_ADDI, OP_ANDI, OP_ORI, OP_XORI};
        rd   = $urandom_range(0, 15);
        rs1  = $urandom_range(0, 15);
        rs2  = $urandom_range(0, 15);
        imm  = $urandom;
        k    = $urandom_range(0, 18);
        if (k < 9)
            return r_word(fns[k], rd, rs1, rs2);
        if (k < 13)
            return i_word(iops[k - 9], rd, rs1, imm);
        case (k)
            13:      return i_word(OP_BEQZ, 5'd0, rs1, imm);
            14:      return i_word(OP_BNEZ, 5'd0, rs1, imm);
            15:      return j_word(OP_J, $urandom);
            16:      return j_word(OP_JAL, $urandom);
            17:      return i_word(OP_JR, 5'd0, rs1, 16'd0);
            default: return i_word(OP_JALR, 5'd0, rs1, 16'd0);
        endcase
    endfunction

    task automatic random_burst();
        test_name = "random";
        for (int i = 1; i < 9; i++)
            run_instr(i_word(OP_ADDI, i[4:0], 5'd0, $urandom), 0);
        for (int i = 0; i < 40; i++)
            run_instr(random_word(), $urandom_range(0, 2));
        drain_reports();
    endtask

    initial begin
        void'($urandom(32'hd6d0da51));
        clk        = 1'b0;
        arst_n     = 1'b0;
        req        = 1'b0;
        instr      = '0;
        next_pc    = '0;
        pc         = 32'h0000_1000;
        mismatches = 0;
        failures   = 0;
        for (int i = 0; i < 32; i++)
            ref_regs[i] = '0;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        rtype_ops();
        imm_ops();
        dep_chain();
        branches();
        jumps();
        random_burst();
        repeat (2) @(negedge clk);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule
